/* Bender.yml */
package:
  name: knight_ctrl

sources:
  - knight_pkg.sv
  - steer_if.sv
  - cmd_link.sv
  - cmd_proc.sv
  - pid_steer.sv
  - knight_ctrl.sv
  - target: simulation
    files:
      - tb_knight_ctrl.sv

/* cmd_link.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_link (
  input  logic                          clk,
  input  logic                          rst_n,
  // Received byte stream.
  input  logic [knight_pkg::BYTE_W-1:0] rx_data,
  input  logic                          rx_valid,
  output logic                          rx_ready,
  // Acknowledge stream.
  output logic [knight_pkg::BYTE_W-1:0] tx_data,
  output logic                          tx_valid,
  input  logic                          tx_ready,
  // Command side.
  output logic [knight_pkg::CMD_W-1:0]  cmd,
  output logic                          cmd_rdy,
  input  logic                          clr_cmd_rdy,
  input  logic                          send_resp
);

  logic rx_fire;                                // Byte accepted this edge.
  logic tx_fire;                                // Ack drained this edge.
  logic low_phase;                              // Next byte is the low half.

  //////////////////////////////
  // Receive side.
  //////////////////////////////
  // One command and one ack outstanding at most.
  assign rx_ready = !cmd_rdy && !tx_valid;
  assign rx_fire  = rx_valid && rx_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      low_phase <= 1'b0;
    end else if (rx_fire) begin
      low_phase <= !low_phase;                  // Alternate high, low.
    end
  end

  always_ff @(posedge clk) begin
    if (rx_fire && !low_phase) begin
      cmd[15:8] <= rx_data;                     // Opcode and heading MSBs.
    end
    if (rx_fire && low_phase) begin
      cmd[7:0] <= rx_data;                      // Heading LSBs and square count.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_rdy <= 1'b0;
    end else if (rx_fire && low_phase) begin
      cmd_rdy <= 1'b1;                          // Second byte completes it.
    end else if (clr_cmd_rdy) begin
      cmd_rdy <= 1'b0;                          // Consumed by the processor.
    end
  end

  //////////////////////////////
  // Acknowledge side.
  //////////////////////////////
  assign tx_fire = tx_valid && tx_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_valid <= 1'b0;
    end else if (send_resp) begin
      tx_valid <= 1'b1;
    end else if (tx_fire) begin
      tx_valid <= 1'b0;                         // Holds through back-pressure.
    end
  end

  always_ff @(posedge clk) begin
    if (send_resp) begin
      tx_data <= knight_pkg::ACK_BYTE;
    end
  end

  // The processor only finishes a command it took, and no command is taken
  // while an ack waits, so a second ack can never stack on the first.
  ack_single_entry : assert property (
    @(posedge clk) disable iff (!rst_n) send_resp |-> !tx_valid
  );

endmodule

`default_nettype wire

/* cmd_proc.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_proc #(
  parameter bit fast_sim = 1'b1                 // Large ramp steps and nudge.
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [knight_pkg::CMD_W-1:0]         cmd,
  input  logic                                 cmd_rdy,
  output logic                                 clr_cmd_rdy,
  output logic                                 send_resp,
  output logic                                 strt_cal,
  input  logic                                 cal_done,
  input  logic signed [knight_pkg::HDG_W-1:0]  heading,
  input  logic                                 heading_rdy,
  input  logic                                 lft_ir,
  input  logic                                 cntr_ir,
  input  logic                                 rght_ir,
  output logic                                 tour_go,
  output logic                                 fanfare_go,
  steer_if.src                                 steer
);

  knight_pkg::cmd_state_t state, nxt_state;
  knight_pkg::opcode_t    opcode;

  logic [knight_pkg::SPD_W-1:0] frwrd;          // Forward speed register.
  logic [knight_pkg::SPD_W-1:0] inc_amt;
  logic [knight_pkg::SPD_W-1:0] dec_amt;
  logic zero;                                   // Speed is fully down.
  logic max_spd;                                // Top two bits set.
  logic clr_frwrd, inc_frwrd, dec_frwrd;        // FSM ramp controls.

  logic       cntr_prev;                        // Centre IR delayed a cycle.
  logic       line_edge;                        // Rising edge on a board line.
  logic [4:0] line_cnt;                         // Lines crossed, two per square.
  logic [3:0] square_cnt;
  logic       clr_lines;
  logic       move_done;
  logic       move_cmd;                         // Move command taken in IDLE.
  logic       is_fanfare;
  logic       moving;

  logic signed [knight_pkg::HDG_W-1:0] desired_hdg;
  logic signed [knight_pkg::HDG_W-1:0] nudge;
  logic signed [knight_pkg::HDG_W-1:0] err;
  logic [knight_pkg::HDG_W-1:0]        err_abs;

  assign opcode = knight_pkg::opcode_t'(cmd[15:12]);

  ////////////////////////////////
  // Forward speed ramp.
  ////////////////////////////////
  assign inc_amt = fast_sim ? knight_pkg::INC_FAST : knight_pkg::INC_SLOW;
  assign dec_amt = fast_sim ? knight_pkg::DEC_FAST : knight_pkg::DEC_SLOW;
  assign zero    = (frwrd == '0);
  assign max_spd = &frwrd[knight_pkg::SPD_W-1:knight_pkg::SPD_W-2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (clr_frwrd) begin
      frwrd <= '0;                              // Fresh start of a move.
    end else if (heading_rdy) begin             // Steps ride on gyro samples.
      if (inc_frwrd && !max_spd) begin
        frwrd <= frwrd + inc_amt;
      end else if (dec_frwrd) begin
        frwrd <= (frwrd > dec_amt) ? frwrd - dec_amt : '0; // Last step lands on zero.
      end
    end
  end

  ////////////////////////////////
  // Line counting.
  ////////////////////////////////
  assign line_edge = cntr_ir && !cntr_prev;
  assign move_done = (line_cnt == {square_cnt, 1'b0});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_prev <= 1'b0;
      line_cnt  <= '0;
    end else begin
      cntr_prev <= cntr_ir;
      if (clr_lines) begin
        line_cnt <= '0;
      end else if (line_edge) begin
        line_cnt <= line_cnt + 5'd1;
      end
    end
  end

  // Command fields are latched once, the link may refill cmd mid-move.
  always_ff @(posedge clk) begin
    if (move_cmd) begin
      square_cnt  <= cmd[3:0];
      is_fanfare  <= (opcode == knight_pkg::FANFARE);
      desired_hdg <= (cmd[11:4] == 8'h00) ? '0 : {cmd[11:4], 4'hF};
    end
  end

  ////////////////////////////////
  // Heading error.
  ////////////////////////////////
  always_comb begin
    if (lft_ir) begin
      nudge = fast_sim ? knight_pkg::NUDGE_FAST : knight_pkg::NUDGE_SLOW;
    end else if (rght_ir) begin
      nudge = fast_sim ? -knight_pkg::NUDGE_FAST : -knight_pkg::NUDGE_SLOW;
    end else begin
      nudge = '0;
    end
  end

  assign err     = heading - desired_hdg + nudge;
  assign err_abs = err[knight_pkg::HDG_W-1] ? -err : err;

  ////////////////////////////////
  // State machine.
  ////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= knight_pkg::IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state   = state;
    clr_cmd_rdy = 1'b0;
    send_resp   = 1'b0;
    strt_cal    = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    move_cmd    = 1'b0;
    clr_lines   = 1'b0;
    clr_frwrd   = 1'b0;
    inc_frwrd   = 1'b0;
    dec_frwrd   = 1'b0;
    moving      = 1'b0;
    case (state)
      knight_pkg::CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;                     // Calibration ack.
          nxt_state = knight_pkg::IDLE;
        end
      end
      knight_pkg::MOVE: begin
        clr_lines = 1'b1;                       // Count from the start line.
        if (err_abs < knight_pkg::ALIGN_TOL) begin
          moving    = 1'b1;
          clr_frwrd = 1'b1;
          nxt_state = knight_pkg::INCR;
        end
      end
      knight_pkg::INCR: begin
        inc_frwrd = 1'b1;
        if (move_done) begin
          fanfare_go = is_fanfare;              // Charge on the way in.
          nxt_state  = knight_pkg::DECR;
        end else begin
          moving = 1'b1;
        end
      end
      knight_pkg::DECR: begin
        dec_frwrd = 1'b1;
        if (zero) begin
          send_resp = 1'b1;                     // Move ack.
          nxt_state = knight_pkg::IDLE;
        end else begin
          moving = 1'b1;
        end
      end
      default: begin                            // IDLE.
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;                   // Taken in the same cycle.
          case (opcode)
            knight_pkg::CAL: begin
              strt_cal  = 1'b1;
              nxt_state = knight_pkg::CALIBRATE;
            end
            knight_pkg::TOUR: tour_go = 1'b1;   // No ack for a tour.
            knight_pkg::MOV, knight_pkg::FANFARE: begin
              move_cmd  = 1'b1;
              nxt_state = knight_pkg::MOVE;
            end
            default: ;                          // Unknown opcode is dropped.
          endcase
        end
      end
    endcase
  end

  assign steer.error       = err;
  assign steer.frwrd       = frwrd;
  assign steer.moving      = moving;
  assign steer.heading_rdy = heading_rdy;

  // The ramp stops one step past the top band at most.
  frwrd_in_band : assert property (
    @(posedge clk) disable iff (!rst_n)
      {1'b0, frwrd} < (11'h300 + {1'b0, inc_amt})
  );

  start_pulses_exclusive : assert property (
    @(posedge clk) disable iff (!rst_n) !(strt_cal && tour_go)
  );

endmodule

`default_nettype wire

/* knight_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module knight_ctrl #(
  parameter bit fast_sim = 1'b1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [knight_pkg::BYTE_W-1:0]         rx_data,
  input  logic                                  rx_valid,
  output logic                                  rx_ready,
  output logic [knight_pkg::BYTE_W-1:0]         tx_data,
  output logic                                  tx_valid,
  input  logic                                  tx_ready,
  output logic                                  strt_cal,
  input  logic                                  cal_done,
  input  logic signed [knight_pkg::HDG_W-1:0]   heading,
  input  logic                                  heading_rdy,
  input  logic                                  lft_ir,
  input  logic                                  cntr_ir,
  input  logic                                  rght_ir,
  output logic signed [knight_pkg::WHEEL_W-1:0] lft_spd,
  output logic signed [knight_pkg::WHEEL_W-1:0] rght_spd,
  output logic                                  moving,
  output logic                                  tour_go,
  output logic                                  fanfare_go
);

  logic [knight_pkg::CMD_W-1:0] cmd;            // Assembled two-byte command.
  logic cmd_rdy, clr_cmd_rdy, send_resp;

  steer_if steer_bus ();                        // Processor to steering.

  cmd_link u_link (
    .clk, .rst_n,
    .rx_data, .rx_valid, .rx_ready,
    .tx_data, .tx_valid, .tx_ready,
    .cmd, .cmd_rdy, .clr_cmd_rdy, .send_resp
  );

  cmd_proc #(.fast_sim(fast_sim)) u_proc (
    .clk, .rst_n,
    .cmd, .cmd_rdy, .clr_cmd_rdy, .send_resp,
    .strt_cal, .cal_done,
    .heading, .heading_rdy,
    .lft_ir, .cntr_ir, .rght_ir,
    .tour_go, .fanfare_go,
    .steer (steer_bus.src)
  );

  pid_steer u_pid (
    .clk, .rst_n,
    .steer (steer_bus.dst),
    .lft_spd, .rght_spd
  );

  assign moving = steer_bus.moving;             // Status back to the gyro side.

endmodule

`default_nettype wire

/* knight_pkg.sv */
`default_nettype none

package knight_pkg;

  //////////////////////////////
  // Command and state encoding.
  //////////////////////////////
  typedef enum logic [3:0] {
    CAL     = 4'b0010,                          // Gyro calibration.
    MOV     = 4'b0100,                          // Straight move.
    FANFARE = 4'b0101,                          // Move, then fanfare on the decel.
    TOUR    = 4'b0110                           // Hand off to the tour solver.
  } opcode_t;

  typedef enum logic [2:0] {
    IDLE,                                       // Waiting for a command.
    CALIBRATE,                                  // Gyro calibration running.
    MOVE,                                       // Aligning to the new heading.
    INCR,                                       // Ramping up and counting lines.
    DECR                                        // Ramping down to a stop.
  } cmd_state_t;

  //////////////////////////////
  // Field widths.
  //////////////////////////////
  localparam int CMD_W   = 16;                  // Two link bytes.
  localparam int BYTE_W  = 8;
  localparam int HDG_W   = 12;                  // Heading and error, signed.
  localparam int SPD_W   = 10;                  // Forward speed, unsigned.
  localparam int WHEEL_W = 12;                  // Wheel speed, signed.
  localparam int INTEG_W = 16;                  // Steering integrator.

  //////////////////////////////
  // Ramp, nudge and steering.
  //////////////////////////////
  localparam logic [SPD_W-1:0] INC_FAST = 10'd32;
  localparam logic [SPD_W-1:0] INC_SLOW = 10'd3;
  localparam logic [SPD_W-1:0] DEC_FAST = 10'd64;
  localparam logic [SPD_W-1:0] DEC_SLOW = 10'd6;
  localparam logic signed [HDG_W-1:0] NUDGE_FAST = 12'sd511;
  localparam logic signed [HDG_W-1:0] NUDGE_SLOW = 12'sd95;
  localparam logic [HDG_W-1:0] ALIGN_TOL = 12'd44;   // |error| must be below this to go.
  localparam logic signed [HDG_W-1:0] ERR_SAT = 12'sd511;
  localparam int P_SHIFT = 1;                   // Kp of 2.
  localparam int I_SHIFT = 6;                   // Ki of 1/64.

  localparam logic [BYTE_W-1:0] ACK_BYTE = 8'hA5;

endpackage

`default_nettype wire

/* pid_steer.sv */
`timescale 1ns/1ps
`default_nettype none

module pid_steer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  steer_if.dst                                  steer,
  output logic signed [knight_pkg::WHEEL_W-1:0] lft_spd,
  output logic signed [knight_pkg::WHEEL_W-1:0] rght_spd
);

  logic signed [knight_pkg::HDG_W-1:0]   err_sat;   // Error clamped to +/-ERR_SAT.
  logic signed [knight_pkg::INTEG_W:0]   integ_sum; // One guard bit for overflow.
  logic signed [knight_pkg::INTEG_W-1:0] integ;
  logic signed [knight_pkg::INTEG_W-1:0] integ_nxt;
  logic signed [knight_pkg::INTEG_W-1:0] corr;      // P plus I term.
  logic signed [knight_pkg::INTEG_W-1:0] lft_raw;
  logic signed [knight_pkg::INTEG_W-1:0] rght_raw;

  // Saturate a wide sum to the wheel range.
  function automatic logic signed [knight_pkg::WHEEL_W-1:0] sat_wheel(
    input logic signed [knight_pkg::INTEG_W-1:0] v
  );
    logic [knight_pkg::INTEG_W-knight_pkg::WHEEL_W:0] top;
    top = v[knight_pkg::INTEG_W-1:knight_pkg::WHEEL_W-1];
    if (v[knight_pkg::INTEG_W-1] && !(&top)) begin
      return {1'b1, {(knight_pkg::WHEEL_W-1){1'b0}}};
    end else if (!v[knight_pkg::INTEG_W-1] && (|top)) begin
      return {1'b0, {(knight_pkg::WHEEL_W-1){1'b1}}};
    end
    return v[knight_pkg::WHEEL_W-1:0];
  endfunction

  always_comb begin
    if (steer.error > knight_pkg::ERR_SAT) begin
      err_sat = knight_pkg::ERR_SAT;
    end else if (steer.error < -knight_pkg::ERR_SAT) begin
      err_sat = -knight_pkg::ERR_SAT;
    end else begin
      err_sat = steer.error;
    end
  end

  //////////////////////////////
  // Integrator and correction.
  //////////////////////////////
  always_comb begin
    integ_sum = integ + err_sat;
    if (integ_sum[knight_pkg::INTEG_W] != integ_sum[knight_pkg::INTEG_W-1]) begin
      integ_nxt = integ_sum[knight_pkg::INTEG_W] ?              // Pin at the rail.
                  {1'b1, {(knight_pkg::INTEG_W-1){1'b0}}} :
                  {1'b0, {(knight_pkg::INTEG_W-1){1'b1}}};
    end else begin
      integ_nxt = integ_sum[knight_pkg::INTEG_W-1:0];
    end
  end

  assign corr     = (err_sat <<< knight_pkg::P_SHIFT) + (integ_nxt >>> knight_pkg::I_SHIFT);
  assign lft_raw  = $signed({1'b0, steer.frwrd}) + corr;
  assign rght_raw = $signed({1'b0, steer.frwrd}) - corr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integ    <= '0;
      lft_spd  <= '0;
      rght_spd <= '0;
    end else if (!steer.moving) begin
      integ    <= '0;                           // Parked, drop any windup.
      lft_spd  <= '0;
      rght_spd <= '0;
    end else if (steer.heading_rdy) begin
      integ    <= integ_nxt;
      lft_spd  <= sat_wheel(lft_raw);
      rght_spd <= sat_wheel(rght_raw);
    end
  end

  // The processor drops moving between commands, so no windup carries over.
  integ_clear_when_parked : assert property (
    @(posedge clk) disable iff (!rst_n) !steer.moving |=> (integ == '0)
  );

endmodule

`default_nettype wire

/* sources.f */
knight_pkg.sv
steer_if.sv
cmd_link.sv
cmd_proc.sv
pid_steer.sv
knight_ctrl.sv
tb_knight_ctrl.sv

/* steer_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface steer_if;

  logic signed [knight_pkg::HDG_W-1:0] error;   // Heading error including nudge.
  logic [knight_pkg::SPD_W-1:0]        frwrd;   // Ramped forward speed.
  logic                                moving;  // Wheels may turn.
  logic                                heading_rdy; // New gyro sample strobe.

  modport src (output error, frwrd, moving, heading_rdy);
  modport dst (input error, frwrd, moving, heading_rdy);

endinterface

`default_nettype wire

/* tb_knight_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_knight_ctrl;

  // Reset, two moves of up to 6 lines, one move of 8 long lines, plus margin.
  localparam int LIMIT = 200 + 2 * (6 * 24 + 150) + (8 * 80 + 150) + 150;

  logic clk = 1'b0;
  logic rst_n;
  logic [knight_pkg::BYTE_W-1:0] rx_data, tx_data;
  logic rx_valid, rx_ready, tx_valid, tx_ready;
  logic strt_cal, cal_done, heading_rdy, lft_ir, cntr_ir, rght_ir;
  logic signed [knight_pkg::HDG_W-1:0]   heading;
  logic signed [knight_pkg::WHEEL_W-1:0] lft_spd, rght_spd;
  logic moving, tour_go, fanfare_go;

  int cycles, err_cnt, err_start, n_pass, n_fail, test_no;
  int cal_cnt, tour_cnt, fan_cnt, ack_cnt, edge_cnt, cmp_cnt;
  int des_hdg, hdg_off, line_gap, gap_cnt, gyro_cnt, stall, seed;
  bit lines_on, jitter_on, moving_s, cntr_q, chk_now;

  knight_pkg::cmd_state_t m_state, m_nxt;        // Reference processor state.
  logic [knight_pkg::CMD_W-1:0] m_cmd;
  bit m_pend, m_phase, m_prev;
  int m_sq, m_des, m_lines, m_frwrd, m_integ, exp_l, exp_r;

  knight_ctrl #(.fast_sim(1'b1)) UUT (.*);

  always #4 clk = !clk;                          // 8 ns period.

  //////////////////////////////
  // Reference model.
  //////////////////////////////
  function automatic int clamp(input int v, input int lo, input int hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  function automatic int error_ref(input int hdg, input int des, input bit lft, input bit rght);
    int e;
    e = hdg - des;
    if (lft) e = e + 511;                        // Left sensor wins.
    else if (rght) e = e - 511;
    e = e & 'hFFF;                               // Wrap to the 12-bit heading.
    return (e > 2047) ? e - 4096 : e;
  endfunction

  function automatic int wheel_ref(input int frwrd, input int es, input int integ, input bit left);
    int corr;
    corr = (es <<< 1) + (integ >>> 6);           // Kp of 2, Ki of 1/64.
    return clamp(left ? frwrd + corr : frwrd - corr, -2048, 2047);
  endfunction

  always @(posedge clk) begin
    int err, es;
    bit done, mv, align;
    if (!rst_n) begin
      m_state = knight_pkg::IDLE;
      {m_pend, m_phase, m_prev, chk_now} = '0;
      {m_lines, m_frwrd, m_integ, exp_l, exp_r} = '0;
    end else begin
      err   = error_ref(heading, m_des, lft_ir, rght_ir);
      done  = (m_lines == 2 * m_sq);
      align = (err > -44) && (err < 44);
      mv    = 1'b0;
      m_nxt = m_state;
      case (m_state)
        knight_pkg::IDLE: if (m_pend) begin
          m_pend = 1'b0;
          case (m_cmd[15:12])
            knight_pkg::CAL: m_nxt = knight_pkg::CALIBRATE;
            knight_pkg::MOV, knight_pkg::FANFARE: begin
              m_sq  = m_cmd[3:0];
              m_des = (m_cmd[11:4] == 0) ? 0 : m_cmd[11:4] * 16 + 15;
              if (m_des > 2047) m_des = m_des - 4096;
              m_nxt = knight_pkg::MOVE;
            end
            default: ;                           // Tour and unknown stay idle.
          endcase
        end
        knight_pkg::CALIBRATE: if (cal_done) m_nxt = knight_pkg::IDLE;
        knight_pkg::MOVE: if (align) begin
          mv    = 1'b1;
          m_nxt = knight_pkg::INCR;
        end
        knight_pkg::INCR: begin
          mv = !done;                            // Drops for the transition cycle.
          if (done) m_nxt = knight_pkg::DECR;
        end
        default: begin
          mv = (m_frwrd != 0);
          if (m_frwrd == 0) m_nxt = knight_pkg::IDLE;
        end
      endcase
      // Steering uses the speed before this edge.
      if (!mv) begin
        {m_integ, exp_l, exp_r} = '0;
      end else if (heading_rdy) begin
        es      = clamp(err, -511, 511);
        m_integ = clamp(m_integ + es, -32768, 32767);
        exp_l   = wheel_ref(m_frwrd, es, m_integ, 1'b1);
        exp_r   = wheel_ref(m_frwrd, es, m_integ, 1'b0);
      end
      if (m_state == knight_pkg::MOVE && align) m_frwrd = 0;
      else if (heading_rdy && m_state == knight_pkg::INCR && m_frwrd < 768) m_frwrd += 32;
      else if (heading_rdy && m_state == knight_pkg::DECR) m_frwrd = clamp(m_frwrd - 64, 0, 1023);
      if (m_state == knight_pkg::MOVE) m_lines = 0;
      else if (cntr_ir && !m_prev) m_lines++;
      m_prev  = cntr_ir;
      m_state = m_nxt;
      chk_now = heading_rdy;                     // Compare on the next falling edge.
      if (rx_valid && rx_ready) begin            // Link byte assembly.
        if (m_phase) begin
          m_cmd[7:0] = rx_data;
          m_pend     = 1'b1;
        end else begin
          m_cmd[15:8] = rx_data;
        end
        m_phase = !m_phase;
      end
    end
  end

  //////////////////////////////
  // Checking and monitors.
  //////////////////////////////
  task automatic check_equal(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      err_cnt++;
    end
  endtask

  always @(negedge clk) begin
    if (chk_now) begin                           // One cycle after heading_rdy.
      chk_now = 1'b0;
      if (lft_spd != 0 || rght_spd != 0) begin
        cmp_cnt++;                               // Wheels were turning.
      end
      check_equal(lft_spd, exp_l, "lft_spd");
      check_equal(rght_spd, exp_r, "rght_spd");
    end
  end

  always @(posedge clk) begin
    moving_s = moving;                           // Stable copy for the line model.
    cycles++;
    if (rst_n) begin
      cal_cnt  += strt_cal;
      tour_cnt += tour_go;
      fan_cnt  += fanfare_go;
      if (cntr_ir && !cntr_q) edge_cnt++;
      if (tx_valid && tx_ready) begin
        ack_cnt++;
        check_equal(tx_data, knight_pkg::ACK_BYTE, "tx_data");
      end
    end
    cntr_q = cntr_ir;
    if (cycles >= LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////
  // Gyro and line models.
  //////////////////////////////
  always @(negedge clk) begin
    if (!rst_n) begin
      gyro_cnt    = 0;
      heading_rdy = 1'b0;
    end else begin
      gyro_cnt    = (gyro_cnt + 1) % 4;
      heading_rdy = (gyro_cnt == 0);             // Sample every 4 cycles.
      if (heading_rdy && jitter_on) begin
        hdg_off = $urandom % 601;
        hdg_off = hdg_off - 300;
        lft_ir  = ($urandom % 4) != 0;           // Mostly positive, winds up.
        rght_ir = $urandom % 2;
      end
      heading = des_hdg + hdg_off;
    end
  end

  always @(negedge clk) begin
    if (!lines_on) begin
      cntr_ir = 1'b0;
      gap_cnt = 0;
    end else if (moving_s) begin
      gap_cnt++;
      if (gap_cnt >= line_gap) begin
        cntr_ir = !cntr_ir;
        gap_cnt = 0;
      end
    end
  end

  //////////////////////////////
  // Stimulus.
  //////////////////////////////
  task automatic send_byte(input logic [knight_pkg::BYTE_W-1:0] b);
    @(negedge clk);
    rx_data  = b;
    rx_valid = 1'b1;
    @(posedge clk);
    while (!rx_ready) @(posedge clk);            // Transfer on this edge.
    @(negedge clk);
    rx_valid = 1'b0;
  endtask

  task automatic send_command(input logic [knight_pkg::CMD_W-1:0] c);
    send_byte(c[15:8]);
    send_byte(c[7:0]);
  endtask

  task automatic close_test(input string name);
    if (err_cnt == err_start) begin
      n_pass++;
      $display("Test %0d %s: pass", test_no, name);
    end else begin
      n_fail++;
      $display("Test %0d %s: FAIL, %0d errors", test_no, name, err_cnt - err_start);
    end
    test_no++;
    err_start = err_cnt;
    {cal_cnt, tour_cnt, fan_cnt, ack_cnt, edge_cnt, cmp_cnt} = '0;
  endtask

  task automatic pulse_cal_done();
    while (cal_cnt == 0) @(posedge clk);
    repeat (3 + $urandom % 8) @(negedge clk);
    cal_done = 1'b1;
    @(negedge clk);
    cal_done = 1'b0;
  endtask

  task automatic run_move(input logic [3:0] op, input int n, input int gap, input bit jit);
    int field;
    {fan_cnt, ack_cnt, edge_cnt, cmp_cnt} = '0;  // Counts belong to this move.
    field   = 1 + $urandom % 255;
    des_hdg = field * 16 + 15;
    hdg_off = $urandom % 61;
    hdg_off = hdg_off - 30;                      // Inside the alignment band.
    line_gap = gap;
    lines_on = 1'b1;
    send_command({op, field[7:0], n[3:0]});
    while (!moving) @(posedge clk);
    jitter_on = jit;
    while (!tx_valid) @(posedge clk);
    jitter_on = 1'b0;
    check_equal(moving, 0, "moving at ack");
    check_equal(edge_cnt >= 2 * n, 1, "line edges before ack");
    repeat (6) @(posedge clk);
    @(negedge clk);
    {lft_ir, rght_ir, lines_on} = '0;
    hdg_off = 0;
    check_equal(ack_cnt, 1, "ack count");
    check_equal(fan_cnt, op == knight_pkg::FANFARE, "fanfare_go pulses");
    check_equal(cmp_cnt > 0, 1, "turning wheel samples compared");
  endtask

  initial begin
    seed = $urandom(32'h872e);
    {rst_n, rx_valid, cal_done, lft_ir, rght_ir, lines_on, jitter_on} = '0;
    {heading_rdy, cntr_ir} = '0;
    rx_data  = '0;
    tx_ready = 1'b1;
    heading  = '0;
    {cycles, err_cnt, err_start, n_pass, n_fail, des_hdg, hdg_off} = '0;
    test_no  = 1;
    line_gap = 12;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_equal({strt_cal, tour_go, fanfare_go, moving, tx_valid}, 0, "controls after reset");
    check_equal(rx_ready, 1, "rx_ready after reset");
    close_test("reset");

    send_command({knight_pkg::CAL, 12'h000});
    pulse_cal_done();
    while (ack_cnt == 0) @(posedge clk);
    repeat (4) @(posedge clk);
    check_equal(cal_cnt, 1, "strt_cal cycles");
    check_equal(ack_cnt, 1, "ack count");
    close_test("calibrate");

    send_command({knight_pkg::TOUR, 12'h000});
    repeat (8) @(posedge clk);
    check_equal(tour_cnt, 1, "tour_go pulses");
    check_equal(ack_cnt, 0, "ack count");
    check_equal(rx_ready, 1, "rx_ready after tour");
    close_test("tour");

    run_move(knight_pkg::MOV, 1 + $urandom % 3, 12, 1'b0);
    run_move(knight_pkg::FANFARE, 1 + $urandom % 3, 12, 1'b0);
    close_test("move and fanfare");

    run_move(knight_pkg::MOV, 4, 40, 1'b1);      // Long move, nudges and offsets.
    close_test("steering");

    @(negedge clk);
    tx_ready = 1'b0;
    send_command({knight_pkg::CAL, 12'h000});
    pulse_cal_done();
    while (!tx_valid) @(posedge clk);
    @(negedge clk);
    rx_valid = 1'b1;                             // Byte pushed against a stall.
    rx_data  = 8'h42;
    stall    = 5 + $urandom % 16;
    repeat (stall) begin
      @(posedge clk);
      check_equal({tx_valid, rx_ready}, 2'b10, "tx_valid and rx_ready under stall");
      check_equal(tx_data, knight_pkg::ACK_BYTE, "tx_data under stall");
    end
    @(negedge clk);
    rx_valid = 1'b0;
    tx_ready = 1'b1;
    while (ack_cnt == 0) @(posedge clk);
    send_command({knight_pkg::TOUR, 12'h000});
    repeat (8) @(posedge clk);
    check_equal(ack_cnt, 1, "ack count");
    check_equal(tour_cnt, 1, "tour_go after drain");
    close_test("back-pressure");

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
